// File: dram_map_macros.svh
/*
 * DRAM channel front end geometry
 * Widths, channel count, bank geometry and request queue depth
 */
`ifndef DRAM_MAP_MACROS_SVH
`define DRAM_MAP_MACROS_SVH

// Channel byte address, one word of data
`define DRAM_CH_ADDR_WIDTH 12
`define DRAM_DATA_WIDTH    32

`define DRAM_NUM_CHANNELS  2

// Bank geometry, row bits are whatever is left of the channel address
`define DRAM_NUM_COLUMNS   8
`define DRAM_NUM_BA        4
`define DRAM_NUM_BG        2
`define DRAM_NUM_RANKS     2

`define DRAM_FIFO_DEPTH    2 // Entries per channel request queue

`endif

// File: dram_map_pkg.sv
/*
 * DRAM address map definitions
 * Mapping modes and the field widths derived from the geometry
 */
`include "dram_map_macros.svh"

package dram_map_pkg;

  // Field order from MSB to LSB, ch marks where the channel bits go
  typedef enum logic [1:0] {
    e_ro_ra_bg_ba_co_ch,
    e_ro_ra_bg_ba_ch_co,
    e_ro_ch_ra_ba_bg_co
  } addr_map_e;

  localparam int lg_channels       = $clog2(`DRAM_NUM_CHANNELS);
  localparam int lg_columns        = $clog2(`DRAM_NUM_COLUMNS);
  localparam int lg_ba             = $clog2(`DRAM_NUM_BA);
  localparam int lg_bg             = $clog2(`DRAM_NUM_BG);
  localparam int lg_ranks          = $clog2(`DRAM_NUM_RANKS);
  localparam int byte_offset_width = $clog2(`DRAM_DATA_WIDTH / 8);

  localparam int lg_rows = `DRAM_CH_ADDR_WIDTH - byte_offset_width - lg_columns
                         - lg_ba - lg_bg - lg_ranks;

  localparam int mem_addr_width = `DRAM_CH_ADDR_WIDTH + lg_channels; // Global DRAM byte address

endpackage

// File: mem_req_pkg.sv
/*
 * Memory request and response payloads
 * Shared by the channel queues and the backing memory pipeline
 */
`include "dram_map_macros.svh"

package mem_req_pkg;

  typedef enum logic {
    e_mem_read,
    e_mem_write
  } mem_cmd_e;

  // One queued request, address already mapped to global DRAM space
  typedef struct packed {
    mem_cmd_e                                cmd;
    logic [dram_map_pkg::mem_addr_width-1:0] addr;
    logic [`DRAM_DATA_WIDTH/8-1:0]           mask;
    logic [`DRAM_DATA_WIDTH-1:0]             data;
  } mem_req_t;

  typedef struct packed {
    logic [dram_map_pkg::lg_channels-1:0] tag; // Issuing channel
    mem_cmd_e                             cmd;
    logic [`DRAM_DATA_WIDTH-1:0]          data; // Zero for writes
  } mem_resp_t;

endpackage

// File: dram_addr_map.sv
/*
 * Channel to global DRAM address mapper
 * Inserts the channel number and reorders fields per mapping mode
 */
`timescale 1ns/1ps
`include "dram_map_macros.svh"

module dram_addr_map #(
  parameter dram_map_pkg::addr_map_e address_mapping_p = dram_map_pkg::e_ro_ra_bg_ba_co_ch,
  parameter int channel_select_p = 0
) (
  input  logic [`DRAM_CH_ADDR_WIDTH-1:0]           ch_addr_i,
  output logic [dram_map_pkg::mem_addr_width-1:0]  mem_addr_o
);

  import dram_map_pkg::*;

  localparam int ch_width_lp = `DRAM_CH_ADDR_WIDTH;
  localparam int col_top_lp  = lg_columns + byte_offset_width;

  localparam logic [lg_channels-1:0] ch_bits_lp = channel_select_p[lg_channels-1:0];

  // Field positions in the channel address
  localparam int co_pos_lp = byte_offset_width;
  localparam int ba_pos_lp = co_pos_lp + lg_columns;
  localparam int bg_pos_lp = ba_pos_lp + lg_ba;
  localparam int ra_pos_lp = bg_pos_lp + lg_bg;
  localparam int ro_pos_lp = ra_pos_lp + lg_ranks;

  // Field positions in the global address for the reordered mode
  localparam int mem_co_pos_lp = byte_offset_width;
  localparam int mem_bg_pos_lp = mem_co_pos_lp + lg_columns;
  localparam int mem_ba_pos_lp = mem_bg_pos_lp + lg_bg;
  localparam int mem_ra_pos_lp = mem_ba_pos_lp + lg_ba;
  localparam int mem_ch_pos_lp = mem_ra_pos_lp + lg_ranks;
  localparam int mem_ro_pos_lp = mem_ch_pos_lp + lg_channels;

  if (address_mapping_p == e_ro_ra_bg_ba_co_ch) begin : g_ch_low
    assign mem_addr_o = {
      ch_addr_i[ch_width_lp-1:byte_offset_width],
      ch_bits_lp,
      {byte_offset_width{1'b0}}
    };
  end else if (address_mapping_p == e_ro_ra_bg_ba_ch_co) begin : g_ch_above_col
    assign mem_addr_o = {
      ch_addr_i[ch_width_lp-1:col_top_lp],
      ch_bits_lp,
      ch_addr_i[col_top_lp-1:byte_offset_width],
      {byte_offset_width{1'b0}}
    };
  end else begin : g_ch_under_row
    // Bit by bit so each field lands at its new offset
    for (genvar i = 0; i < mem_addr_width; i++) begin : g_bit
      if (i >= mem_ro_pos_lp && i < mem_ro_pos_lp + lg_rows) begin : g_ro
        assign mem_addr_o[i] = ch_addr_i[ro_pos_lp+i-mem_ro_pos_lp];
      end else if (i >= mem_ch_pos_lp && i < mem_ro_pos_lp) begin : g_ch
        assign mem_addr_o[i] = ch_bits_lp[i-mem_ch_pos_lp];
      end else if (i >= mem_ra_pos_lp && i < mem_ch_pos_lp) begin : g_ra
        assign mem_addr_o[i] = ch_addr_i[ra_pos_lp+i-mem_ra_pos_lp];
      end else if (i >= mem_ba_pos_lp && i < mem_ra_pos_lp) begin : g_ba
        assign mem_addr_o[i] = ch_addr_i[ba_pos_lp+i-mem_ba_pos_lp];
      end else if (i >= mem_bg_pos_lp && i < mem_ba_pos_lp) begin : g_bg
        assign mem_addr_o[i] = ch_addr_i[bg_pos_lp+i-mem_bg_pos_lp];
      end else if (i >= mem_co_pos_lp && i < mem_bg_pos_lp) begin : g_co
        assign mem_addr_o[i] = ch_addr_i[co_pos_lp+i-mem_co_pos_lp];
      end else begin : g_off
        assign mem_addr_o[i] = 1'b0; // Byte offset
      end
    end
  end

endmodule

// File: dram_req_fifo.sv
/*
 * Request queue
 * Small circular buffer FIFO, payload type set per instance
 */
`timescale 1ns/1ps

module dram_req_fifo #(
  parameter type payload_t = logic,
  parameter int  depth_p   = 2
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     wr_valid_i,
  output logic     wr_ready_o,
  input  payload_t wr_data_i,
  output logic     rd_valid_o,
  input  logic     rd_ready_i,
  output payload_t rd_data_o
);

  localparam int ptr_width_lp   = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int count_width_lp = $clog2(depth_p + 1);

  payload_t                  mem_r [depth_p];
  logic [ptr_width_lp-1:0]   wr_ptr_r, rd_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic                      push, pop;

  assign wr_ready_o = (count_r != count_width_lp'(depth_p));
  assign rd_valid_o = (count_r != '0);
  assign rd_data_o  = mem_r[rd_ptr_r];

  assign push = wr_valid_i && wr_ready_o;
  assign pop  = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      if (push && !pop) count_r <= count_r + 1'b1;
      else if (pop && !push) count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_r[wr_ptr_r] <= wr_data_i;
  end

  // When full the write pointer sits on the unread head and no push may land
  a_no_write_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    (count_r == count_width_lp'(depth_p)) |-> !push && (wr_ptr_r == rd_ptr_r));

endmodule

// File: dram_rr_arbiter.sv
/*
 * Round-robin arbiter over channel queue heads
 * Grant is locked until the memory accepts it
 */
`timescale 1ns/1ps
`include "dram_map_macros.svh"

module dram_rr_arbiter (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [`DRAM_NUM_CHANNELS-1:0]        req_i,
  input  logic                                 accept_i,
  output logic [`DRAM_NUM_CHANNELS-1:0]        grant_o,
  output logic [dram_map_pkg::lg_channels-1:0] grant_id_o
);

  import dram_map_pkg::*;

  localparam int num_lp = `DRAM_NUM_CHANNELS;

  logic [lg_channels-1:0] ptr_r;      // First channel to consider
  logic                   lock_r;
  logic [lg_channels-1:0] lock_id_r;
  logic [lg_channels-1:0] search_id;
  logic                   found, grant_valid;

  always_comb begin
    int idx;
    found     = 1'b0;
    search_id = '0;
    for (int k = 0; k < num_lp; k++) begin
      idx = (int'(ptr_r) + k) % num_lp;
      if (!found && req_i[idx]) begin
        found     = 1'b1;
        search_id = idx[lg_channels-1:0];
      end
    end
  end

  assign grant_valid = lock_r || found;
  assign grant_id_o  = lock_r ? lock_id_r : search_id;

  always_comb begin
    grant_o = '0;
    if (grant_valid) grant_o[grant_id_o] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_r     <= '0;
      lock_r    <= 1'b0;
      lock_id_r <= '0;
    end else begin
      lock_r    <= grant_valid && !accept_i;
      lock_id_r <= grant_id_o;
      if (grant_valid && accept_i) begin
        ptr_r <= (grant_id_o == lg_channels'(num_lp - 1)) ? '0 : grant_id_o + 1'b1;
      end
    end
  end

  // At most one grant and only to a channel with a queued request
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant_o) && ((grant_o & ~req_i) == '0));

  // A stall must not let another channel jump the queue
  a_grant_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (grant_o != '0) && !accept_i |=> grant_o == $past(grant_o));

endmodule

// File: dram_backing_mem.sv
/*
 * Shared DRAM model
 * Flat word array behind a two-stage pipeline that stalls on back-pressure
 */
`timescale 1ns/1ps
`include "dram_map_macros.svh"

module dram_backing_mem (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  input  mem_req_pkg::mem_req_t                req_i,
  input  logic [dram_map_pkg::lg_channels-1:0] req_tag_i,
  output logic                                 resp_valid_o,
  input  logic                                 resp_ready_i,
  output mem_req_pkg::mem_resp_t               resp_o
);

  import dram_map_pkg::*;
  import mem_req_pkg::*;

  localparam int word_addr_width_lp = mem_addr_width - byte_offset_width;
  localparam int num_words_lp       = 1 << word_addr_width_lp;
  localparam int mask_width_lp      = `DRAM_DATA_WIDTH / 8;

  logic [`DRAM_DATA_WIDTH-1:0] mem_r [num_words_lp];

  logic                          s1_valid_r, s2_valid_r;
  mem_req_t                      s1_req_r;
  logic [lg_channels-1:0]        s1_tag_r;
  mem_resp_t                     s2_resp_r;
  logic [word_addr_width_lp-1:0] s1_word;
  logic                          advance;

  assign advance     = !(s2_valid_r && !resp_ready_i); // Whole pipe freezes on a stall
  assign req_ready_o = advance;
  assign s1_word     = s1_req_r.addr[mem_addr_width-1:byte_offset_width];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid_r <= 1'b0;
      s2_valid_r <= 1'b0;
    end else if (advance) begin
      s1_valid_r <= req_valid_i;
      s2_valid_r <= s1_valid_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_req_r       <= req_i;
      s1_tag_r       <= req_tag_i;
      s2_resp_r.tag  <= s1_tag_r;
      s2_resp_r.cmd  <= s1_req_r.cmd;
      s2_resp_r.data <= (s1_req_r.cmd == e_mem_read) ? mem_r[s1_word] : '0;
    end
  end

  // Stage one write, only masked bytes change
  always_ff @(posedge clk_i) begin
    if (advance && s1_valid_r && s1_req_r.cmd == e_mem_write) begin
      for (int b = 0; b < mask_width_lp; b++) begin
        if (s1_req_r.mask[b]) mem_r[s1_word][8*b +: 8] <= s1_req_r.data[8*b +: 8];
      end
    end
  end

  assign resp_valid_o = s2_valid_r;
  assign resp_o       = s2_resp_r;

  a_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

// File: dram_channel_subsys.sv
/*
 * Two-channel DRAM front end
 * Per-channel mapping and queues, shared memory, tagged response return
 */
`timescale 1ns/1ps
`include "dram_map_macros.svh"

module dram_channel_subsys #(
  parameter dram_map_pkg::addr_map_e address_mapping_p = dram_map_pkg::e_ro_ra_bg_ba_co_ch
) (
  input  logic                                                       clk_i,
  input  logic                                                       reset_i,
  input  logic [`DRAM_NUM_CHANNELS-1:0]                              ch_req_valid_i,
  output logic [`DRAM_NUM_CHANNELS-1:0]                              ch_req_ready_o,
  input  logic [`DRAM_NUM_CHANNELS-1:0]                              ch_req_we_i,
  input  logic [`DRAM_NUM_CHANNELS-1:0][`DRAM_CH_ADDR_WIDTH-1:0]     ch_req_addr_i,
  input  logic [`DRAM_NUM_CHANNELS-1:0][`DRAM_DATA_WIDTH/8-1:0]      ch_req_mask_i,
  input  logic [`DRAM_NUM_CHANNELS-1:0][`DRAM_DATA_WIDTH-1:0]        ch_req_wdata_i,
  output logic [`DRAM_NUM_CHANNELS-1:0]                              ch_resp_valid_o,
  input  logic [`DRAM_NUM_CHANNELS-1:0]                              ch_resp_ready_i,
  output logic [`DRAM_NUM_CHANNELS-1:0]                              ch_resp_we_o,
  output logic [`DRAM_NUM_CHANNELS-1:0][`DRAM_DATA_WIDTH-1:0]        ch_resp_rdata_o
);

  import dram_map_pkg::*;
  import mem_req_pkg::*;

  localparam int num_lp = `DRAM_NUM_CHANNELS;

  logic [mem_addr_width-1:0] mapped_addr [num_lp];
  mem_req_t                  fifo_wr_data [num_lp];
  mem_req_t                  fifo_rd_data [num_lp];
  logic [num_lp-1:0]         fifo_rd_valid, fifo_rd_ready;

  logic [num_lp-1:0]      grant;
  logic [lg_channels-1:0] grant_id;
  logic                   mem_req_valid, mem_req_ready;
  logic                   mem_resp_valid, mem_resp_ready;
  mem_resp_t              mem_resp;

  for (genvar i = 0; i < num_lp; i++) begin : g_ch
    dram_addr_map #(
      .address_mapping_p(address_mapping_p),
      .channel_select_p (i)
    ) u_dram_addr_map (
      .ch_addr_i (ch_req_addr_i[i]),
      .mem_addr_o(mapped_addr[i])
    );

    assign fifo_wr_data[i].cmd  = ch_req_we_i[i] ? e_mem_write : e_mem_read;
    assign fifo_wr_data[i].addr = mapped_addr[i];
    assign fifo_wr_data[i].mask = ch_req_mask_i[i];
    assign fifo_wr_data[i].data = ch_req_wdata_i[i];

    dram_req_fifo #(
      .payload_t(mem_req_t),
      .depth_p  (`DRAM_FIFO_DEPTH)
    ) u_dram_req_fifo (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .wr_valid_i(ch_req_valid_i[i]),
      .wr_ready_o(ch_req_ready_o[i]),
      .wr_data_i (fifo_wr_data[i]),
      .rd_valid_o(fifo_rd_valid[i]),
      .rd_ready_i(fifo_rd_ready[i]),
      .rd_data_o (fifo_rd_data[i])
    );

    assign fifo_rd_ready[i] = grant[i] && mem_req_ready; // Pop in the accept cycle

    // Response fans out, only the tagged channel sees valid
    assign ch_resp_valid_o[i] = mem_resp_valid && (mem_resp.tag == lg_channels'(i));
    assign ch_resp_we_o[i]    = (mem_resp.cmd == e_mem_write);
    assign ch_resp_rdata_o[i] = mem_resp.data;
  end

  dram_rr_arbiter u_dram_rr_arbiter (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (fifo_rd_valid),
    .accept_i  (mem_req_valid && mem_req_ready),
    .grant_o   (grant),
    .grant_id_o(grant_id)
  );

  assign mem_req_valid  = |grant;
  assign mem_resp_ready = ch_resp_ready_i[mem_resp.tag];

  dram_backing_mem u_dram_backing_mem (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .req_i       (fifo_rd_data[grant_id]),
    .req_tag_i   (grant_id),
    .resp_valid_o(mem_resp_valid),
    .resp_ready_i(mem_resp_ready),
    .resp_o      (mem_resp)
  );

endmodule

// File: tb_dram_channel_subsys.sv
/*
 * Testbench for the two-channel DRAM front end
 * Replays the tests file on both channels and checks every response
 */
`timescale 1ns/1ps
`include "dram_map_macros.svh"

module tb_dram_channel_subsys;

  localparam int num_ch_lp    = `DRAM_NUM_CHANNELS;
  localparam int max_tests_lp = 64;

  logic                                            clk_i;
  logic                                            reset_i;
  logic [num_ch_lp-1:0]                            ch_req_valid_i;
  logic [num_ch_lp-1:0]                            ch_req_ready_o;
  logic [num_ch_lp-1:0]                            ch_req_we_i;
  logic [num_ch_lp-1:0][`DRAM_CH_ADDR_WIDTH-1:0]   ch_req_addr_i;
  logic [num_ch_lp-1:0][`DRAM_DATA_WIDTH/8-1:0]    ch_req_mask_i;
  logic [num_ch_lp-1:0][`DRAM_DATA_WIDTH-1:0]      ch_req_wdata_i;
  logic [num_ch_lp-1:0]                            ch_resp_valid_o;
  logic [num_ch_lp-1:0]                            ch_resp_ready_i;
  logic [num_ch_lp-1:0]                            ch_resp_we_o;
  logic [num_ch_lp-1:0][`DRAM_DATA_WIDTH-1:0]      ch_resp_rdata_o;

  // One entry per line of the tests file
  logic [8*24-1:0]                t_name  [max_tests_lp];
  int                             t_ch    [max_tests_lp];
  logic                           t_we    [max_tests_lp];
  logic [`DRAM_CH_ADDR_WIDTH-1:0] t_addr  [max_tests_lp];
  logic [`DRAM_DATA_WIDTH/8-1:0]  t_mask  [max_tests_lp];
  logic [`DRAM_DATA_WIDTH-1:0]    t_wdata [max_tests_lp];
  logic [`DRAM_DATA_WIDTH-1:0]    t_exp   [max_tests_lp];

  int                   num_tests;
  int                   reset_errors;
  logic                 loaded;
  logic                 start;
  logic [num_ch_lp-1:0] done_vec;

  dram_channel_subsys #(
    .address_mapping_p(dram_map_pkg::e_ro_ch_ra_ba_bg_co)
  ) u_dram_channel_subsys (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .ch_req_valid_i (ch_req_valid_i),
    .ch_req_ready_o (ch_req_ready_o),
    .ch_req_we_i    (ch_req_we_i),
    .ch_req_addr_i  (ch_req_addr_i),
    .ch_req_mask_i  (ch_req_mask_i),
    .ch_req_wdata_i (ch_req_wdata_i),
    .ch_resp_valid_o(ch_resp_valid_o),
    .ch_resp_ready_i(ch_resp_ready_i),
    .ch_resp_we_o   (ch_resp_we_o),
    .ch_resp_rdata_o(ch_resp_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic load_tests(output int count, output int bad);
    int              fd;
    int              code;
    string           line;
    logic [8*24-1:0] nm;
    logic [31:0]     f_ch, f_we, f_addr, f_mask, f_wdata, f_exp;
    count = 0;
    bad   = 0;
    fd    = $fopen("dram_map_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dram_map_tests.txt for reading");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          code = $sscanf(line, "%s %h %h %h %h %h %h",
                         nm, f_ch, f_we, f_addr, f_mask, f_wdata, f_exp);
          if (code != 7 || f_ch >= num_ch_lp || count >= max_tests_lp) begin
            $display("Malformed or extra line in tests file: %0s", line);
            bad++;
          end else begin
            t_name[count]  = nm;
            t_ch[count]    = int'(f_ch);
            t_we[count]    = f_we[0];
            t_addr[count]  = f_addr[`DRAM_CH_ADDR_WIDTH-1:0];
            t_mask[count]  = f_mask[`DRAM_DATA_WIDTH/8-1:0];
            t_wdata[count] = f_wdata;
            t_exp[count]   = f_exp;
            count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Idle state right after reset, before any request
  task automatic check_reset_state();
    if (ch_resp_valid_o !== '0) begin
      $display("** Error reset: resp_valid expected %b, actual %b", {num_ch_lp{1'b0}},
               ch_resp_valid_o);
      reset_errors++;
    end
    if (ch_req_ready_o !== {num_ch_lp{1'b1}}) begin
      $display("** Error reset: req_ready expected %b, actual %b", {num_ch_lp{1'b1}},
               ch_req_ready_o);
      reset_errors++;
    end
  endtask

  for (genvar c = 0; c < num_ch_lp; c++) begin : g_chan
    logic                           req_valid, req_we;
    logic [`DRAM_CH_ADDR_WIDTH-1:0] req_addr;
    logic [`DRAM_DATA_WIDTH/8-1:0]  req_mask;
    logic [`DRAM_DATA_WIDTH-1:0]    req_wdata;
    int                             resp_count;
    int                             errors;
    logic                           done;

    assign ch_req_valid_i[c] = req_valid;
    assign ch_req_we_i[c]    = req_we;
    assign ch_req_addr_i[c]  = req_addr;
    assign ch_req_mask_i[c]  = req_mask;
    assign ch_req_wdata_i[c] = req_wdata;
    assign done_vec[c]       = done;

    initial begin : driver
      logic ready_seen;
      req_valid = 1'b0;
      req_we    = 1'b0;
      req_addr  = '0;
      req_mask  = '0;
      req_wdata = '0;
      wait (start);
      for (int i = 0; i < num_tests; i++) begin
        if (t_ch[i] == c) begin
          req_valid = 1'b1;
          req_we    = t_we[i];
          req_addr  = t_addr[i];
          req_mask  = t_mask[i];
          req_wdata = t_wdata[i];
          do begin
            ready_seen = ch_req_ready_o[c]; // Depends on queue state only
            @(posedge clk_i);
          end while (!ready_seen);
          #1;
          req_valid = 1'b0;
        end
      end
    end

    initial begin : monitor
      resp_count = 0;
      errors     = 0;
      done       = 1'b0;
      wait (start);
      for (int i = 0; i < num_tests; i++) begin
        if (t_ch[i] == c) begin
          do begin
            @(posedge clk_i);
            #2;
          end while (!(ch_resp_valid_o[c] && ch_resp_ready_i[c]));
          if (ch_resp_we_o[c] !== t_we[i]) begin
            $display("** Error %0s: we expected %b, actual %b", t_name[i], t_we[i],
                     ch_resp_we_o[c]);
            errors++;
          end
          if (ch_resp_rdata_o[c] !== t_exp[i]) begin
            $display("** Error %0s: rdata expected %h, actual %h", t_name[i], t_exp[i],
                     ch_resp_rdata_o[c]);
            errors++;
          end
          resp_count++;
        end
      end
      done = 1'b1;
    end
  end

  // Random back-pressure on both response ports
  initial begin : resp_ready_gen
    int          seed;
    logic [31:0] rnd;
    seed            = 32;
    ch_resp_ready_i = '0;
    wait (start);
    forever begin
      rnd             = $random(seed);
      ch_resp_ready_i = rnd[num_ch_lp-1:0];
      @(posedge clk_i);
      #1;
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (num_tests * 40 + 100) @(posedge clk_i);
    $display("Timeout after %0d cycles, not every response came back", num_tests * 40 + 100);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    int n;
    int bad;
    reset_i      = 1'b1;
    start        = 1'b0;
    loaded       = 1'b0;
    reset_errors = 0;
    num_tests    = 0;
    load_tests(n, bad);
    if (n == 0 || bad != 0) begin
      $display("Tests file unusable, %0d tests read, %0d bad lines", n, bad);
      $display("Test failed");
      $finish;
    end else begin
      num_tests = n;
      loaded    = 1'b1;
      repeat (4) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      check_reset_state();
      start = 1'b1;
      wait (&done_vec);
      repeat (4) @(posedge clk_i);
      $display("Errors: reset %0d, channel 0 %0d, channel 1 %0d, responses %0d of %0d",
               reset_errors, g_chan[0].errors, g_chan[1].errors,
               g_chan[0].resp_count + g_chan[1].resp_count, num_tests);
      if (reset_errors + g_chan[0].errors + g_chan[1].errors == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

// File: dram_map_tests.txt
# name ch we addr mask wdata expect   (all but name in hex, we 1 marks a write)
# expect is the response data, zero for writes, reads only touch written words
wr_rd_c0_w      0 1 010 f 12345678 00000000
wr_rd_c0_r      0 0 010 f 00000000 12345678
iso_c0_w        0 1 040 f aaaa0000 00000000
iso_c1_w        1 1 040 f 0000bbbb 00000000
iso_c0_r        0 0 040 f 00000000 aaaa0000
iso_c1_r        1 0 040 f 00000000 0000bbbb
mask_c1_full    1 1 0c0 f 11223344 00000000
mask_c1_b02     1 1 0c0 5 aabbccdd 00000000
mask_c1_r1      1 0 0c0 f 00000000 11bb33dd
mask_c1_b13     1 1 0c0 a 55667788 00000000
mask_c1_r2      1 0 0c0 f 00000000 55bb77dd
mask_c1_none    1 1 0c0 0 ffffffff 00000000
mask_c1_r3      1 0 0c0 f 00000000 55bb77dd
mask_c0_full    0 1 0e0 f deadbeef 00000000
mask_c0_b3      0 1 0e0 8 00000000 00000000
mask_c0_r       0 0 0e0 f 00000000 00adbeef
alias_base_w    0 1 000 f 0a000000 00000000
alias_col_w     0 1 004 f 0a000001 00000000
alias_ba_w      0 1 020 f 0a000002 00000000
alias_bg_w      0 1 080 f 0a000003 00000000
alias_ra_w      0 1 100 f 0a000004 00000000
alias_row_w     0 1 200 f 0a000005 00000000
alias_base_r    0 0 000 f 00000000 0a000000
alias_col_r     0 0 004 f 00000000 0a000001
alias_ba_r      0 0 020 f 00000000 0a000002
alias_bg_r      0 0 080 f 00000000 0a000003
alias_ra_r      0 0 100 f 00000000 0a000004
alias_row_r     0 0 200 f 00000000 0a000005
alias_c1_rowmsb 1 1 800 f 0b000001 00000000
alias_c1_colmax 1 1 01c f 0b000002 00000000
alias_c1_base   1 1 000 f 0b000003 00000000
alias_c1_rm_r   1 0 800 f 00000000 0b000001
alias_c1_cm_r   1 0 01c f 00000000 0b000002
alias_c1_b_r    1 0 000 f 00000000 0b000003
burst_c1_w0     1 1 3f0 f c0c0c0c0 00000000
burst_c1_w1     1 1 3f4 f c1c1c1c1 00000000
burst_c1_w2     1 1 3f8 f c2c2c2c2 00000000
burst_c1_w3     1 1 3fc f c3c3c3c3 00000000
burst_c1_r0     1 0 3f0 f 00000000 c0c0c0c0
burst_c1_r1     1 0 3f4 f 00000000 c1c1c1c1
burst_c1_r2     1 0 3f8 f 00000000 c2c2c2c2
burst_c1_r3     1 0 3fc f 00000000 c3c3c3c3

// File: dram_channel_subsys.f
+incdir+.
dram_map_pkg.sv
mem_req_pkg.sv
dram_addr_map.sv
dram_req_fifo.sv
dram_rr_arbiter.sv
dram_backing_mem.sv
dram_channel_subsys.sv
tb_dram_channel_subsys.sv

// File: Makefile
# Verilator build and run for the two-channel DRAM front end

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dram_channel_subsys
FILELIST  = dram_channel_subsys.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test passed

SOURCES   = $(wildcard *.sv) $(wildcard *.svh)
SIM_BIN   = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code alone is not trusted
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
